//--- build.f
+incdir+design
design/mul_div_ctrl_pkg.sv
design/mdc_operand_classifier.sv
design/mdc_fast_result.sv
design/mdc_sequencer.sv
design/riscv_core_mul_div_ctrl.sv
verification/mul_div_ctrl_sva.sv
verification/tb_mul_div_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f build.f --top-module tb_mul_div_ctrl -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

//--- verification/tb_mul_div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_div_ctrl_consts.svh"

module tb_mul_div_ctrl
  import mul_div_ctrl_pkg::*;
;

  localparam logic [31:0] LFSR_SEED = 32'h473353ba;
  localparam int FAST_LEN  = 3;
  localparam int SLOW_LEN  = 11; // Request, start, up to 8 waits, done
  localparam int TOTAL_LEN = 6 + 19 * FAST_LEN + 6 * SLOW_LEN;

  logic        clk;
  logic        rstn;
  logic        en;
  logic        isword;
  mdc_op_t     control;
  mdc_dword_t  src_a;
  mdc_dword_t  src_b;
  logic        mul_dn;
  logic        div_dn;
  mdc_dword_t  out_fast;
  logic        mul_start;
  logic        div_start;
  logic        busy;
  logic        done;
  logic        div_by_zero;
  logic        overflow;
  logic        mul_div_sel;
  logic        out_sel;
  logic [31:0] stim_lfsr;
  logic [31:0] lat_lfsr;
  logic [63:0] lat_bits;
  logic [3:0]  mul_cnt;
  logic [3:0]  div_cnt;
  int          errors;
  int          tests_run;
  int          tests_failed;

  riscv_core_mul_div_ctrl UUT (
    .i_mul_div_ctrl_srcA        (src_a),
    .i_mul_div_ctrl_srcB        (src_b),
    .i_mul_div_ctrl_control     (control),
    .i_mul_div_ctrl_en          (en),
    .i_mul_div_ctrl_isword      (isword),
    .i_mul_div_ctrl_clk         (clk),
    .i_mul_div_ctrl_rstn        (rstn),
    .i_mul_div_ctrl_mul_dn      (mul_dn),
    .i_mul_div_ctrl_div_dn      (div_dn),
    .o_mul_div_ctrl_out_fast    (out_fast),
    .o_mul_div_ctrl_mul_start   (mul_start),
    .o_mul_div_ctrl_div_start   (div_start),
    .o_mul_div_ctrl_busy        (busy),
    .o_mul_div_ctrl_done        (done),
    .o_mul_div_ctrl_div_by_zero (div_by_zero),
    .o_mul_div_ctrl_overflow    (overflow),
    .o_mul_div_ctrl_mul_div_sel (mul_div_sel),
    .o_mul_div_ctrl_out_sel     (out_sel)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[62:0], st[0]};
      st  = lfsr_next(st);
    end
  endtask

  // Bit 1 set and bit 2 clear keeps both widths off 0, 1, -1 and min
  task automatic slow_operand(output mdc_dword_t v);
    draw_bits(stim_lfsr, 64, v);
    v = (v | 64'h2) & ~64'h4;
  endtask

  // Multiplier and divider stand-ins with done after 1 to 8 cycles
  always @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      lat_lfsr = LFSR_SEED;
      mul_cnt <= '0;
      div_cnt <= '0;
      mul_dn  <= 1'b0;
      div_dn  <= 1'b0;
    end
    else
    begin
      mul_dn <= (mul_cnt == 4'd1);
      div_dn <= (div_cnt == 4'd1);
      if (mul_cnt != '0)
        mul_cnt <= mul_cnt - 4'd1;
      if (div_cnt != '0)
        div_cnt <= div_cnt - 4'd1;
      if (mul_start || div_start)
      begin
        draw_bits(lat_lfsr, 3, lat_bits);
        if (mul_start)
          mul_cnt <= 4'(lat_bits[2:0]) + 4'd1;
        else
          div_cnt <= 4'(lat_bits[2:0]) + 4'd1;
      end
    end
  end

  task automatic check_dword(input string what, input mdc_dword_t got, input mdc_dword_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("PASS  %s", name);
    else
    begin
      tests_failed++;
      $display("FAIL  %s with %0d mismatches", name, errors - err_before);
    end
  endtask

  task automatic check_quiet(input string when);
    check_bit({"mul_start ", when}, mul_start, 1'b0);
    check_bit({"div_start ", when}, div_start, 1'b0);
    check_bit({"busy ", when}, busy, 1'b0);
    check_bit({"done ", when}, done, 1'b0);
    check_bit({"out_sel ", when}, out_sel, 1'b0);
    check_bit({"div_by_zero ", when}, div_by_zero, 1'b0);
    check_bit({"overflow ", when}, overflow, 1'b0);
    check_bit({"mul_div_sel ", when}, mul_div_sel, 1'b0);
    check_dword({"out_fast ", when}, out_fast, '0);
  endtask

  task automatic drive_req(input mdc_op_t op, input logic w, input mdc_dword_t a,
                           input mdc_dword_t b);
    @(posedge clk);
    en      <= 1'b1;
    control <= op;
    isword  <= w;
    src_a   <= a;
    src_b   <= b;
  endtask

  task automatic run_fast(input mdc_op_t op, input logic w, input mdc_dword_t a,
                          input mdc_dword_t b, input mdc_dword_t exp_res,
                          input logic exp_dbz, input logic exp_ovf);
    drive_req(op, w, a, b);
    @(negedge clk);
    check_bit("busy on accept", busy, 1'b1);
    check_bit("start on fast request", mul_start | div_start, 1'b0);
    @(posedge clk);
    en    <= 1'b0;
    src_a <= ~a; // Result must come from the register
    src_b <= ~b;
    @(negedge clk);
    check_bit("fast done", done, 1'b1);
    check_bit("busy in fast done", busy, 1'b0);
    check_bit("out_sel", out_sel, 1'b1);
    check_bit("mul_div_sel", mul_div_sel, op[2]);
    check_dword("out_fast", out_fast, exp_res);
    check_bit("div_by_zero", div_by_zero, exp_dbz);
    check_bit("overflow", overflow, exp_ovf);
    @(negedge clk);
    check_bit("done after fast", done, 1'b0);
  endtask

  task automatic run_slow(input mdc_op_t op, input logic w, input mdc_dword_t a,
                          input mdc_dword_t b, input logic hold_en);
    int n;
    drive_req(op, w, a, b);
    @(negedge clk);
    check_bit("mul_start", mul_start, !op[2]);
    check_bit("div_start", div_start, op[2]);
    check_bit("busy on start", busy, 1'b1);
    check_bit("mul_div_sel", mul_div_sel, op[2]);
    @(posedge clk);
    en <= hold_en;
    n = 0;
    @(negedge clk);
    while (!done && n < 20)
    begin
      check_bit("busy while running", busy, 1'b1);
      check_bit("second start before done", mul_start | div_start, 1'b0);
      n++;
      @(negedge clk);
    end
    if (!done)
    begin
      errors++;
      $display("Error at %0t: no done within 20 cycles of a unit start", $time);
    end
    else
    begin
      check_bit("unit done with done", op[2] ? div_dn : mul_dn, 1'b1);
      check_bit("busy in slow done", busy, 1'b0);
      check_bit("out_sel in slow done", out_sel, 1'b0);
      check_dword("out_fast in slow done", out_fast, '0);
      check_bit("flags in slow done", div_by_zero | overflow, 1'b0);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (2)
    begin
      @(negedge clk);
      check_quiet("in reset");
    end
    @(posedge clk);
    rstn <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_quiet("after reset");
    end
    report_test("reset", e0);
  endtask

  task automatic test_div_edges();
    mdc_dword_t ra;
    mdc_dword_t rb;
    int         e0;
    e0 = errors;
    slow_operand(ra);
    slow_operand(rb);
    run_fast(`MDC_OP_DIV, 1'b0, ra, '0, '1, 1'b1, 1'b0);
    run_fast(`MDC_OP_DIVU, 1'b0, ra, '0, '1, 1'b1, 1'b0);
    run_fast(`MDC_OP_REM, 1'b0, ra, '0, ra, 1'b1, 1'b0);
    run_fast(`MDC_OP_REMU, 1'b0, ra, '0, ra, 1'b1, 1'b0);
    run_fast(`MDC_OP_DIV, 1'b0, 64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000, 1'b0, 1'b1);
    run_fast(`MDC_OP_REM, 1'b0, 64'h8000_0000_0000_0000, '1, '0, 1'b0, 1'b1);
    run_fast(`MDC_OP_DIV, 1'b1, {ra[63:32], 32'h8000_0000}, {rb[63:32], 32'hffff_ffff},
             64'hffff_ffff_8000_0000, 1'b0, 1'b1);
    report_test("division edge cases", e0);
  endtask

  task automatic test_identities();
    mdc_dword_t ra;
    mdc_dword_t rb;
    int         e0;
    e0 = errors;
    slow_operand(ra);
    slow_operand(rb);
    run_fast(`MDC_OP_MULHU, 1'b0, '0, rb, '0, 1'b0, 1'b0);
    run_fast(`MDC_OP_DIV, 1'b0, '0, rb, '0, 1'b0, 1'b0);
    run_fast(`MDC_OP_MUL, 1'b0, ra, 64'd1, ra, 1'b0, 1'b0);
    run_fast(`MDC_OP_MULH, 1'b0, ra | 64'h8000_0000_0000_0000, 64'd1, '1, 1'b0, 1'b0);
    run_fast(`MDC_OP_MULHSU, 1'b0, ra & 64'h7fff_ffff_ffff_ffff, 64'd1, '0, 1'b0, 1'b0);
    run_fast(`MDC_OP_REMU, 1'b0, ra, 64'd1, '0, 1'b0, 1'b0);
    run_fast(`MDC_OP_DIVU, 1'b0, ra, 64'd1, ra, 1'b0, 1'b0);
    run_fast(`MDC_OP_MUL, 1'b0, 64'd1, rb, rb, 1'b0, 1'b0);
    // Word mode with garbage upper halves
    run_fast(`MDC_OP_MUL, 1'b1, {ra[63:32], 32'h8000_1234}, {rb[63:32], 32'h1},
             64'hffff_ffff_8000_1234, 1'b0, 1'b0);
    run_fast(`MDC_OP_MUL, 1'b1, {ra[63:32], 32'h1}, {rb[63:32], 32'h0000_7fff},
             64'h0000_0000_0000_7fff, 1'b0, 1'b0);
    run_fast(`MDC_OP_DIVU, 1'b1, {ra[63:32], 32'h0}, rb, '0, 1'b0, 1'b0);
    run_fast(`MDC_OP_REMU, 1'b1, {ra[63:32], 32'hfedc_ba98}, {rb[63:32], 32'h0},
             64'hffff_ffff_fedc_ba98, 1'b1, 1'b0);
    report_test("identity cases", e0);
  endtask

  task automatic test_slow(input string name, input mdc_op_t op_d, input mdc_op_t op_w,
                           input logic word_b_one);
    mdc_dword_t ra;
    mdc_dword_t rb;
    int         e0;
    e0 = errors;
    slow_operand(ra);
    slow_operand(rb);
    run_slow(op_d, 1'b0, ra, rb, 1'b0);
    run_slow(op_w, 1'b1, ra, word_b_one ? {rb[63:32], 32'h1} : rb, 1'b0);
    report_test(name, e0);
  endtask

  task automatic test_ignored_start();
    mdc_dword_t ra;
    mdc_dword_t rb;
    int         e0;
    e0 = errors;
    slow_operand(ra);
    slow_operand(rb);
    run_slow(`MDC_OP_MULHSU, 1'b0, ra, rb, 1'b1); // en stays high
    run_slow(`MDC_OP_DIVU, 1'b0, rb, ra, 1'b0);
    report_test("ignored start", e0);
  endtask

  initial
  begin
    repeat (TOTAL_LEN * 20) @(posedge clk);
    $display("Watchdog expired: the tests did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    stim_lfsr    = LFSR_SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rstn    <= 1'b0;
    en      <= 1'b0;
    isword  <= 1'b0;
    control <= `MDC_OP_MUL;
    src_a   <= '0;
    src_b   <= '0;
    test_reset();
    test_div_edges();
    test_identities();
    test_slow("slow multiply", `MDC_OP_MUL, `MDC_OP_MULH, 1'b1);
    test_slow("slow divide", `MDC_OP_DIV, `MDC_OP_REMU, 1'b0);
    test_ignored_start();
    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/mul_div_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mul_div_ctrl_sva
  import mul_div_ctrl_pkg::*;
(
  input logic       i_clk,
  input logic       i_rstn,
  input mdc_state_t i_state,
  input logic       i_mul_start,
  input logic       i_div_start,
  input logic       i_busy,
  input logic       i_done
);

  a_mul_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
    i_mul_start |=> !i_mul_start)
    else $error("mul_start held for more than one cycle");

  a_div_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
    i_div_start |=> !i_div_start)
    else $error("div_start held for more than one cycle");

  a_one_start: assert property (@(posedge i_clk) disable iff (!i_rstn)
    !(i_mul_start && i_div_start))
    else $error("mul_start and div_start high together");

  a_no_done_idle: assert property (@(posedge i_clk) disable iff (!i_rstn)
    (i_state == IDLE) |-> !i_done)
    else $error("done raised in IDLE");

  a_busy_done: assert property (@(posedge i_clk) disable iff (!i_rstn)
    !(i_busy && i_done))
    else $error("busy and done high together");

endmodule

bind mdc_sequencer mul_div_ctrl_sva u_sva (
  .i_clk       (i_mul_div_ctrl_clk),
  .i_rstn      (i_mul_div_ctrl_rstn),
  .i_state     (state_q),
  .i_mul_start (o_mul_start),
  .i_div_start (o_div_start),
  .i_busy      (o_busy),
  .i_done      (o_done)
);

`default_nettype wire

//--- design/riscv_core_mul_div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_div_ctrl_consts.svh"

module riscv_core_mul_div_ctrl
  import mul_div_ctrl_pkg::*;
(
  input  mdc_dword_t i_mul_div_ctrl_srcA,
  input  mdc_dword_t i_mul_div_ctrl_srcB,
  input  mdc_op_t    i_mul_div_ctrl_control,
  input  logic       i_mul_div_ctrl_en,
  input  logic       i_mul_div_ctrl_isword,
  input  logic       i_mul_div_ctrl_clk,
  input  logic       i_mul_div_ctrl_rstn,
  input  logic       i_mul_div_ctrl_mul_dn,
  input  logic       i_mul_div_ctrl_div_dn,
  output mdc_dword_t o_mul_div_ctrl_out_fast,
  output logic       o_mul_div_ctrl_mul_start,
  output logic       o_mul_div_ctrl_div_start,
  output logic       o_mul_div_ctrl_busy,
  output logic       o_mul_div_ctrl_done,
  output logic       o_mul_div_ctrl_div_by_zero,
  output logic       o_mul_div_ctrl_overflow,
  output logic       o_mul_div_ctrl_mul_div_sel,
  output logic       o_mul_div_ctrl_out_sel
);

  mdc_req_t   req;
  mdc_class_t class_d;
  mdc_class_t class_w;
  mdc_fast_t  fast_comb;
  mdc_fast_t  fast_reg;

  assign req.op     = i_mul_div_ctrl_control;
  assign req.isword = i_mul_div_ctrl_isword;
  assign req.src_a  = i_mul_div_ctrl_srcA;
  assign req.src_b  = i_mul_div_ctrl_srcB;

  mdc_operand_classifier #(.operand_t(mdc_dword_t)) u_class_d (
    .i_src_a (req.src_a),
    .i_src_b (req.src_b),
    .o_class (class_d)
  );

  mdc_operand_classifier #(.operand_t(mdc_word_t)) u_class_w (
    .i_src_a (req.src_a[`MDC_WLEN-1:0]), // Low halves
    .i_src_b (req.src_b[`MDC_WLEN-1:0]),
    .o_class (class_w)
  );

  mdc_fast_result u_fast (
    .i_req     (req),
    .i_class_d (class_d),
    .i_class_w (class_w),
    .o_fast    (fast_comb)
  );

  mdc_sequencer u_seq (
    .i_mul_div_ctrl_clk  (i_mul_div_ctrl_clk),
    .i_mul_div_ctrl_rstn (i_mul_div_ctrl_rstn),
    .i_en                (i_mul_div_ctrl_en),
    .i_is_div            (req.op[2]),
    .i_fast              (fast_comb),
    .i_mul_dn            (i_mul_div_ctrl_mul_dn),
    .i_div_dn            (i_mul_div_ctrl_div_dn),
    .o_mul_start         (o_mul_div_ctrl_mul_start),
    .o_div_start         (o_mul_div_ctrl_div_start),
    .o_busy              (o_mul_div_ctrl_busy),
    .o_done              (o_mul_div_ctrl_done),
    .o_fast              (fast_reg)
  );

  assign o_mul_div_ctrl_out_fast    = fast_reg.result;
  assign o_mul_div_ctrl_div_by_zero = fast_reg.div_by_zero;
  assign o_mul_div_ctrl_overflow    = fast_reg.overflow;
  assign o_mul_div_ctrl_out_sel     = fast_reg.hit;
  assign o_mul_div_ctrl_mul_div_sel = req.op[2]; // Divider path

endmodule

`default_nettype wire

//--- design/mdc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mdc_sequencer
  import mul_div_ctrl_pkg::*;
(
  input  logic      i_mul_div_ctrl_clk,
  input  logic      i_mul_div_ctrl_rstn,
  input  logic      i_en,
  input  logic      i_is_div,
  input  mdc_fast_t i_fast,
  input  logic      i_mul_dn,
  input  logic      i_div_dn,
  output logic      o_mul_start,
  output logic      o_div_start,
  output logic      o_busy,
  output logic      o_done,
  output mdc_fast_t o_fast
);

  mdc_state_t state_q;
  mdc_state_t state_d;
  mdc_fast_t  fast_q;
  logic       accept;

  assign accept = (state_q == IDLE) & i_en;

  always_ff @(posedge i_mul_div_ctrl_clk, negedge i_mul_div_ctrl_rstn)
  begin
    if (!i_mul_div_ctrl_rstn)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Operands may change after acceptance
  always_ff @(posedge i_mul_div_ctrl_clk)
  begin
    if (accept)
    begin
      fast_q <= i_fast;
    end
  end

  always_comb
  begin
    state_d     = state_q;
    o_mul_start = 1'b0;
    o_div_start = 1'b0;
    o_busy      = 1'b0;
    o_done      = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (i_en)
        begin
          o_busy = 1'b1;
          if (i_fast.hit)
          begin
            state_d = FAST;
          end
          else if (i_is_div)
          begin
            state_d     = DIV;
            o_div_start = 1'b1;
          end
          else
          begin
            state_d     = MUL;
            o_mul_start = 1'b1;
          end
        end
      end
      FAST:
      begin
        o_done  = 1'b1; // Registered result valid here
        state_d = IDLE;
      end
      MUL:
      begin
        if (i_mul_dn)
        begin
          o_done  = 1'b1;
          state_d = IDLE;
        end
        else
        begin
          o_busy = 1'b1;
        end
      end
      DIV:
      begin
        if (i_div_dn)
        begin
          o_done  = 1'b1;
          state_d = IDLE;
        end
        else
        begin
          o_busy = 1'b1;
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  assign o_fast = (state_q == FAST) ? fast_q : '0; // Only shown in FAST

endmodule

`default_nettype wire

//--- design/mdc_fast_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_div_ctrl_consts.svh"

module mdc_fast_result
  import mul_div_ctrl_pkg::*;
(
  input  mdc_req_t   i_req,
  input  mdc_class_t i_class_d,
  input  mdc_class_t i_class_w,
  output mdc_fast_t  o_fast
);

  localparam mdc_dword_t MIN_D = {1'b1, {(`MDC_XLEN-1){1'b0}}};
  localparam mdc_word_t  MIN_W = {1'b1, {(`MDC_WLEN-1){1'b0}}};

  function automatic mdc_dword_t sext_word(input mdc_word_t w);
    sext_word = {{(`MDC_XLEN-`MDC_WLEN){w[`MDC_WLEN-1]}}, w};
  endfunction

  mdc_class_t cls;
  mdc_dword_t a_val;
  mdc_dword_t b_val;
  mdc_dword_t min_val;
  logic       signed_div;
  logic       hi_mul_word;

  // Word mode looks at low halves only
  assign cls     = i_req.isword ? i_class_w : i_class_d;
  assign a_val   = i_req.isword ? sext_word(i_req.src_a[`MDC_WLEN-1:0]) : i_req.src_a;
  assign b_val   = i_req.isword ? sext_word(i_req.src_b[`MDC_WLEN-1:0]) : i_req.src_b;
  assign min_val = i_req.isword ? sext_word(MIN_W) : MIN_D;

  assign signed_div  = i_req.op[2] & ~i_req.op[0]; // DIV, REM
  assign hi_mul_word = i_req.isword & ~i_req.op[2] & (i_req.op[1:0] != 2'b00);

  always_comb
  begin
    o_fast = '0;
    if (signed_div && cls.a_min && cls.b_ones)
    begin
      o_fast.hit      = 1'b1;
      o_fast.overflow = 1'b1;
      if (!i_req.op[1])
      begin
        o_fast.result = min_val; // REM leaves 0
      end
    end
    else if (cls.b_zero)
    begin
      o_fast.hit = 1'b1;
      if (i_req.op[2])
      begin
        o_fast.div_by_zero = 1'b1;
        if (i_req.op[1])
        begin
          o_fast.result = a_val;
        end
        else
        begin
          o_fast.result = '1;
        end
      end
      // Any multiply by zero stays 0
    end
    else if (cls.a_zero)
    begin
      o_fast.hit = 1'b1;
    end
    else if (cls.b_one)
    begin
      o_fast.hit = 1'b1;
      case (i_req.op)
        `MDC_OP_MUL,
        `MDC_OP_DIV,
        `MDC_OP_DIVU:
        begin
          o_fast.result = a_val;
        end
        `MDC_OP_MULH,
        `MDC_OP_MULHSU:
        begin
          o_fast.result = {`MDC_XLEN{a_val[`MDC_XLEN-1]}}; // Sign fill
        end
        `MDC_OP_MULHU,
        `MDC_OP_REM,
        `MDC_OP_REMU:
        begin
          o_fast.result = '0;
        end
        default:
        begin
          o_fast.result = '0;
        end
      endcase
    end
    else if (cls.a_one && (i_req.op == `MDC_OP_MUL))
    begin
      o_fast.hit    = 1'b1;
      o_fast.result = b_val;
    end

    // High multiplies in word mode always go to the multiplier
    if (hi_mul_word)
    begin
      o_fast = '0;
    end
  end

endmodule

`default_nettype wire

//--- design/mdc_operand_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module mdc_operand_classifier
  import mul_div_ctrl_pkg::*;
#(
  parameter type operand_t = mdc_dword_t
)
(
  input  operand_t   i_src_a,
  input  operand_t   i_src_b,
  output mdc_class_t o_class
);

  localparam int       W       = $bits(operand_t);
  localparam operand_t ONE     = operand_t'(1);
  localparam operand_t MIN_VAL = ONE << (W - 1); // Sign bit only

  always_comb
  begin
    o_class.a_zero = (i_src_a == '0);
    o_class.a_one  = (i_src_a == ONE);
    o_class.a_min  = (i_src_a == MIN_VAL);
    o_class.b_zero = (i_src_b == '0);
    o_class.b_one  = (i_src_b == ONE);
    o_class.b_ones = (&i_src_b); // -1 when signed
  end

endmodule

`default_nettype wire

//--- design/mul_div_ctrl_pkg.sv
`default_nettype none

`include "mul_div_ctrl_consts.svh"

package mul_div_ctrl_pkg;

  typedef logic [`MDC_XLEN-1:0] mdc_dword_t;
  typedef logic [`MDC_WLEN-1:0] mdc_word_t;
  typedef logic [2:0]           mdc_op_t; // funct3

  typedef struct packed {
    mdc_op_t    op;
    logic       isword; // 32-bit W variant
    mdc_dword_t src_a;
    mdc_dword_t src_b;
  } mdc_req_t;

  // Special operand values at one width
  typedef struct packed {
    logic a_zero;
    logic a_one;
    logic a_min; // Most negative
    logic b_zero;
    logic b_one;
    logic b_ones; // All ones
  } mdc_class_t;

  typedef struct packed {
    logic       hit;
    mdc_dword_t result;
    logic       div_by_zero;
    logic       overflow;
  } mdc_fast_t;

  typedef enum logic [1:0] {
    IDLE,
    FAST,
    MUL,
    DIV
  } mdc_state_t;

endpackage

`default_nettype wire

//--- design/mul_div_ctrl_consts.svh
`ifndef MUL_DIV_CTRL_CONSTS_SVH
`define MUL_DIV_CTRL_CONSTS_SVH

// Operand widths
`define MDC_XLEN 64
`define MDC_WLEN 32

// funct3 codes of the M extension
`define MDC_OP_MUL    3'd0
`define MDC_OP_MULH   3'd1
`define MDC_OP_MULHSU 3'd2
`define MDC_OP_MULHU  3'd3
`define MDC_OP_DIV    3'd4 // Bit 2 marks divide class
`define MDC_OP_DIVU   3'd5
`define MDC_OP_REM    3'd6 // Bit 1 marks remainder
`define MDC_OP_REMU   3'd7

`endif
